// ==== verilog/dram_consts.svh ====
// dram subsystem constants: widths, storage depth, bank geometry and access timing

`ifndef DRAM_CONSTS_SVH
`define DRAM_CONSTS_SVH

// bus widths
`define DRAM_ADDR_W 32  // byte address
`define DRAM_DATA_W 64  // one data word

// storage and geometry
`define DRAM_WORDS  1024
`define DRAM_COL_W  5   // 32 words per row
`define DRAM_BANK_W 2   // 4 banks
`define DRAM_ROW_W  3

// access latency in cycles
`define DRAM_T_HIT  3   // row already open
`define DRAM_T_MISS 8   // activate needed

// queue depths
`define DRAM_RSP_DEPTH 4
`define ORDER_DEPTH    8

`endif

// ==== verilog/dram_pkg.sv ====
// dram subsystem package: shared vector types, channel structs and engine states

`include "dram_consts.svh"

package dram_pkg;

  // byte address, word bits split as column, bank, row
  typedef logic [`DRAM_ADDR_W-1:0] addr_t;
  typedef logic [`DRAM_DATA_W-1:0] data_t;

  typedef logic [0:0] port_id_t;  // requester index

  typedef logic [`DRAM_BANK_W-1:0] bank_t;
  typedef logic [`DRAM_ROW_W-1:0]  row_t;

  // request channel payload
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // response channel payload, reads only
  typedef struct packed {
    data_t rdata;
  } mem_rsp_t;

  typedef enum logic {
    DRAM_IDLE,
    DRAM_ACCESS
  } dram_state_e;

endpackage : dram_pkg

// ==== verilog/mem_req_arbiter.sv ====
// request arbiter: round-robin merge of two request ports onto the dram channel
`timescale 1ns/1ps

module mem_req_arbiter (
  input  logic                clk_i,
  input  logic                rst_ni,
  // requester 0
  input  logic                req0_valid_i,
  output logic                req0_ready_o,
  input  dram_pkg::mem_req_t  req0_i,
  // requester 1
  input  logic                req1_valid_i,
  output logic                req1_ready_o,
  input  dram_pkg::mem_req_t  req1_i,
  // merged channel to dram
  output logic                dram_req_valid_o,
  input  logic                dram_req_ready_i,
  output dram_pkg::mem_req_t  dram_req_o,
  // read order towards router
  output logic                order_push_o,
  output dram_pkg::port_id_t  order_port_o,
  input  logic                order_ready_i
);

  import dram_pkg::*;

  port_id_t   last_q;       // port served last
  port_id_t   lock_port_q;
  logic       lock_q;       // grant held while dram stalls
  port_id_t   grant;
  logic [1:0] elig;
  logic       xfer;

  always_comb begin
    // a read may only go when the router can record its port
    elig[0] = req0_valid_i & (req0_i.we | order_ready_i);
    elig[1] = req1_valid_i & (req1_i.we | order_ready_i);

    if (lock_q) begin
      grant = lock_port_q;
    end else if (elig[~last_q]) begin
      grant = ~last_q;  // other port first
    end else begin
      grant = last_q;
    end

    dram_req_valid_o = elig[grant];
    dram_req_o       = (grant == 1'b1) ? req1_i : req0_i;
  end

  // a port is ready unless the other one holds the grant
  assign req0_ready_o = dram_req_ready_i & (req0_i.we | order_ready_i) &
                        ~(dram_req_valid_o & (grant != 1'b0));
  assign req1_ready_o = dram_req_ready_i & (req1_i.we | order_ready_i) &
                        ~(dram_req_valid_o & (grant != 1'b1));

  assign xfer         = dram_req_valid_o & dram_req_ready_i;
  assign order_push_o = xfer & ~dram_req_o.we;  // reads only
  assign order_port_o = grant;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      last_q <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= dram_req_valid_o & ~dram_req_ready_i;
      if (xfer) last_q <= grant;
    end
  end

  always_ff @(posedge clk_i) begin
    lock_port_q <= grant;  // only read while lock_q is set
  end

endmodule : mem_req_arbiter

// ==== verilog/mem_rsp_router.sv ====
// response router: order queue of read port ids steering dram responses to their port
`timescale 1ns/1ps

`include "dram_consts.svh"

module mem_rsp_router (
  input  logic                clk_i,
  input  logic                rst_ni,
  // read order from arbiter
  input  logic                order_push_i,
  input  dram_pkg::port_id_t  order_port_i,
  output logic                order_ready_o,
  // responses from dram
  input  logic                dram_rsp_valid_i,
  output logic                dram_rsp_ready_o,
  input  dram_pkg::mem_rsp_t  dram_rsp_i,
  // port 0
  output logic                rsp0_valid_o,
  input  logic                rsp0_ready_i,
  output dram_pkg::mem_rsp_t  rsp0_o,
  // port 1
  output logic                rsp1_valid_o,
  input  logic                rsp1_ready_i,
  output dram_pkg::mem_rsp_t  rsp1_o
);

  import dram_pkg::*;

  localparam int unsigned OrdPtrW = $clog2(`ORDER_DEPTH);
  localparam logic [OrdPtrW:0] OrdDepth = `ORDER_DEPTH;

  port_id_t           ord_q [`ORDER_DEPTH];
  logic [OrdPtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [OrdPtrW:0]   count_q;
  port_id_t           head;
  logic               has_head;
  logic               pop;

  assign head          = ord_q[rd_ptr_q];
  assign has_head      = (count_q != '0);
  assign order_ready_o = (count_q != OrdDepth);

  // steer to the oldest outstanding read
  assign rsp0_valid_o     = dram_rsp_valid_i & has_head & (head == 1'b0);
  assign rsp1_valid_o     = dram_rsp_valid_i & has_head & (head == 1'b1);
  assign rsp0_o           = dram_rsp_i;
  assign rsp1_o           = dram_rsp_i;
  assign dram_rsp_ready_o = has_head & ((head == 1'b1) ? rsp1_ready_i : rsp0_ready_i);

  assign pop = dram_rsp_valid_i & dram_rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (order_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;  // wraps at depth
      if (order_push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !order_push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (order_push_i) ord_q[wr_ptr_q] <= order_port_i;
  end

endmodule : mem_rsp_router

// ==== verilog/sim_dram.sv ====
// behavioral dram: banked word storage with open-row latency and a read response queue
`timescale 1ns/1ps

`include "dram_consts.svh"

module sim_dram (
  input  logic                clk_i,
  input  logic                rst_ni,
  // request channel
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  dram_pkg::mem_req_t  req_i,
  // read response channel
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output dram_pkg::mem_rsp_t  rsp_o
);

  import dram_pkg::*;

  localparam int unsigned NumBanks = 2 ** `DRAM_BANK_W;
  localparam int unsigned WordW    = `DRAM_COL_W + `DRAM_BANK_W + `DRAM_ROW_W;
  localparam int unsigned ByteOffW = $clog2(`DRAM_DATA_W / 8);
  localparam int unsigned CntW     = $clog2(`DRAM_T_MISS);
  localparam int unsigned RspPtrW  = $clog2(`DRAM_RSP_DEPTH);
  localparam logic [RspPtrW:0] RspDepth = `DRAM_RSP_DEPTH;

  // storage and bank state
  data_t               mem_q [`DRAM_WORDS];
  row_t                open_row_q [NumBanks];
  logic [NumBanks-1:0] row_open_q;  // cleared by reset, all rows closed

  // access engine
  dram_state_e         state_q;
  logic [CntW-1:0]     cnt_q;
  mem_req_t            cur_q;  // request being served
  logic                access_done;

  // read response queue
  data_t               rsp_mem [`DRAM_RSP_DEPTH];
  logic [RspPtrW-1:0]  rsp_wr_q, rsp_rd_q;
  logic [RspPtrW:0]    rsp_cnt_q;
  logic                rsp_push, rsp_pop;

  // address decode
  logic [WordW-1:0]    req_word, cur_word;
  bank_t               req_bank, cur_bank;
  row_t                req_row, cur_row;
  logic                req_hit;

  assign req_word = req_i.addr[ByteOffW +: WordW];
  assign req_bank = req_word[`DRAM_COL_W +: `DRAM_BANK_W];
  assign req_row  = req_word[`DRAM_COL_W + `DRAM_BANK_W +: `DRAM_ROW_W];
  assign cur_word = cur_q.addr[ByteOffW +: WordW];
  assign cur_bank = cur_word[`DRAM_COL_W +: `DRAM_BANK_W];
  assign cur_row  = cur_word[`DRAM_COL_W + `DRAM_BANK_W +: `DRAM_ROW_W];

  assign req_hit = row_open_q[req_bank] && (open_row_q[req_bank] == req_row);

  // no read is pending while idle, so queue space alone decides
  assign req_ready_o = (state_q == DRAM_IDLE) && (rsp_cnt_q != RspDepth);

  assign access_done = (state_q == DRAM_ACCESS) && (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= DRAM_IDLE;
      cnt_q      <= '0;
      row_open_q <= '0;
    end else begin
      case (state_q)
        DRAM_IDLE: begin
          if (req_valid_i && req_ready_o) begin
            state_q <= DRAM_ACCESS;
            cnt_q   <= req_hit ? CntW'(`DRAM_T_HIT - 1) : CntW'(`DRAM_T_MISS - 1);
          end
        end
        DRAM_ACCESS: begin
          if (cnt_q == '0) begin
            state_q              <= DRAM_IDLE;
            row_open_q[cur_bank] <= 1'b1;  // row stays open for later hits
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= DRAM_IDLE;
      endcase
    end
  end

  // latch request, open row, do the write at completion
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) cur_q <= req_i;
    if (access_done) begin
      open_row_q[cur_bank] <= cur_row;
      if (cur_q.we) mem_q[cur_word] <= cur_q.wdata;
    end
  end

  assign rsp_push = access_done & ~cur_q.we;
  assign rsp_pop  = rsp_valid_o & rsp_ready_i;

  assign rsp_valid_o = (rsp_cnt_q != '0);
  assign rsp_o.rdata = rsp_mem[rsp_rd_q];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rsp_wr_q  <= '0;
      rsp_rd_q  <= '0;
      rsp_cnt_q <= '0;
    end else begin
      if (rsp_push) rsp_wr_q <= rsp_wr_q + 1'b1;
      if (rsp_pop) rsp_rd_q <= rsp_rd_q + 1'b1;
      if (rsp_push && !rsp_pop) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end else if (rsp_pop && !rsp_push) begin
        rsp_cnt_q <= rsp_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_push) rsp_mem[rsp_wr_q] <= mem_q[cur_word];  // space reserved at accept
  end

endmodule : sim_dram

// ==== verilog/mem_subsys_top.sv ====
// memory subsystem top: two requesters sharing one dram through arbiter and router
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // request ports
  input  logic                req0_valid_i,
  output logic                req0_ready_o,
  input  dram_pkg::mem_req_t  req0_i,
  input  logic                req1_valid_i,
  output logic                req1_ready_o,
  input  dram_pkg::mem_req_t  req1_i,
  // response ports
  output logic                rsp0_valid_o,
  input  logic                rsp0_ready_i,
  output dram_pkg::mem_rsp_t  rsp0_o,
  output logic                rsp1_valid_o,
  input  logic                rsp1_ready_i,
  output dram_pkg::mem_rsp_t  rsp1_o
);

  import dram_pkg::*;

  logic     dram_req_valid, dram_req_ready;
  mem_req_t dram_req;
  logic     dram_rsp_valid, dram_rsp_ready;
  mem_rsp_t dram_rsp;
  logic     order_push, order_ready;
  port_id_t order_port;

  mem_req_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .req0_valid_i, .req0_ready_o, .req0_i,
    .req1_valid_i, .req1_ready_o, .req1_i,
    .dram_req_valid_o (dram_req_valid),
    .dram_req_ready_i (dram_req_ready),
    .dram_req_o       (dram_req),
    .order_push_o     (order_push),
    .order_port_o     (order_port),
    .order_ready_i    (order_ready)
  );

  sim_dram i_dram (
    .clk_i, .rst_ni,
    .req_valid_i (dram_req_valid),
    .req_ready_o (dram_req_ready),
    .req_i       (dram_req),
    .rsp_valid_o (dram_rsp_valid),
    .rsp_ready_i (dram_rsp_ready),
    .rsp_o       (dram_rsp)
  );

  mem_rsp_router i_router (
    .clk_i, .rst_ni,
    .order_push_i     (order_push),
    .order_port_i     (order_port),
    .order_ready_o    (order_ready),
    .dram_rsp_valid_i (dram_rsp_valid),
    .dram_rsp_ready_o (dram_rsp_ready),
    .dram_rsp_i       (dram_rsp),
    .rsp0_valid_o, .rsp0_ready_i, .rsp0_o,
    .rsp1_valid_o, .rsp1_ready_i, .rsp1_o
  );

endmodule : mem_subsys_top

// ==== tests/tb_mem_subsys.sv ====
// memory subsystem testbench: two-port traffic checked against a shadow memory model
`timescale 1ns/1ps

`include "dram_consts.svh"

module tb_mem_subsys;

  import dram_pkg::*;

  localparam int unsigned WordW    = `DRAM_COL_W + `DRAM_BANK_W + `DRAM_ROW_W;
  localparam int unsigned ByteOffW = $clog2(`DRAM_DATA_W / 8);
  localparam int unsigned ColW     = `DRAM_COL_W;
  localparam int unsigned PoolSize = 32;  // one word for each bank and row
  localparam int unsigned TimeoutCycles = 20000;  // ~600 transfers, up to ~30 cycles each

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  logic [1:0] req_valid = 2'b00;
  logic [1:0] rsp_ready = 2'b11;
  logic [1:0] req_ready, rsp_valid;
  mem_req_t   req [2] = '{default: '0};
  mem_rsp_t   rsp [2];

  data_t       shadow [`DRAM_WORDS];  // latest write per word, in acceptance order
  data_t       exp0_q [$];
  data_t       exp1_q [$];
  mem_req_t    pend0_q [$];
  mem_req_t    pend1_q [$];
  logic [1:0]  acc;  // transfer seen at the last rising edge
  logic        gaps = 1'b0;
  logic        rand_ready = 1'b0;
  logic        alt_en = 1'b0;
  logic        alt_have;
  port_id_t    alt_last;
  int unsigned cycles = 0;

  mem_subsys_top i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req0_valid_i (req_valid[0]),
    .req0_ready_o (req_ready[0]),
    .req0_i       (req[0]),
    .req1_valid_i (req_valid[1]),
    .req1_ready_o (req_ready[1]),
    .req1_i       (req[1]),
    .rsp0_valid_o (rsp_valid[0]),
    .rsp0_ready_i (rsp_ready[0]),
    .rsp0_o       (rsp[0]),
    .rsp1_valid_o (rsp_valid[1]),
    .rsp1_ready_i (rsp_ready[1]),
    .rsp1_o       (rsp[1])
  );

  always #50 clk = ~clk;

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0d ns: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_port(string name, port_id_t got, port_id_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0d ns: %s got %0d expected %0d",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0d ns: %s got %b expected %b",
                          $time, name, got, exp));
    end
  endtask

  // expected read data, low 3 address bits ignored
  function automatic data_t ref_read(addr_t addr);
    return shadow[addr[ByteOffW +: WordW]];
  endfunction

  // word address of pool entry: row from the upper index bits, bank from the lower
  function automatic addr_t pool_addr(int unsigned idx);
    logic [WordW-1:0] word;
    word = {row_t'(idx >> `DRAM_BANK_W), bank_t'(idx), ColW'((idx * 11) % 32)};
    return addr_t'(word) << ByteOffW;
  endfunction

  function automatic mem_req_t make_req(logic we, addr_t addr, data_t wdata);
    mem_req_t r;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic mem_req_t rand_req();
    addr_t addr;
    addr = pool_addr($urandom_range(0, PoolSize - 1)) | addr_t'($urandom_range(0, 7));
    return make_req(1'($urandom_range(0, 1)), addr, {$urandom, $urandom});
  endfunction

  task automatic record_accept(port_id_t port, mem_req_t r);
    if (alt_en && req_valid == 2'b11) begin
      if (alt_have) check_port("accepted port", port, ~alt_last);
      alt_last = port;
      alt_have = 1'b1;
    end else if (!alt_en) begin
      alt_have = 1'b0;
    end
    if (r.we) begin
      shadow[r.addr[ByteOffW +: WordW]] = r.wdata;
    end else if (port == 1'b0) begin
      exp0_q.push_back(ref_read(r.addr));
    end else begin
      exp1_q.push_back(ref_read(r.addr));
    end
  endtask

  // all queued requests accepted, responses may still be in flight
  task automatic wait_drained();
    while (pend0_q.size() != 0 || pend1_q.size() != 0 || req_valid != 2'b00) begin
      @(negedge clk);
    end
  endtask

  // request monitor, port level acceptance order
  always @(posedge clk) begin
    acc = req_valid & req_ready & {2{rst_n}};
    if (acc[0]) record_accept(1'b0, req[0]);
    if (acc[1]) record_accept(1'b1, req[1]);
  end

  // response compare against the expected queues
  always @(posedge clk) begin
    if (rst_n && rsp_valid[0] && rsp_ready[0]) begin
      if (exp0_q.size() == 0) begin
        abort_run("port 0 returned a response with no read outstanding");
      end else begin
        check_data("rsp0_o.rdata", rsp[0].rdata, exp0_q.pop_front());
      end
    end
    if (rst_n && rsp_valid[1] && rsp_ready[1]) begin
      if (exp1_q.size() == 0) begin
        abort_run("port 1 returned a response with no read outstanding");
      end else begin
        check_data("rsp1_o.rdata", rsp[1].rdata, exp1_q.pop_front());
      end
    end
  end

  // falling edge driver, payload held until the transfer
  always @(negedge clk) begin
    if (acc[0]) req_valid[0] = 1'b0;
    if (acc[1]) req_valid[1] = 1'b0;
    if (!req_valid[0] && pend0_q.size() != 0 && (!gaps || $urandom_range(0, 2) != 0)) begin
      req[0]       = pend0_q.pop_front();
      req_valid[0] = 1'b1;
    end
    if (!req_valid[1] && pend1_q.size() != 0 && (!gaps || $urandom_range(0, 2) != 0)) begin
      req[1]       = pend1_q.pop_front();
      req_valid[1] = 1'b1;
    end
    rsp_ready[0] = !rand_ready || ($urandom_range(0, 2) != 0);
    rsp_ready[1] = !rand_ready || ($urandom_range(0, 2) != 0);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) abort_run("timeout: transfers did not complete in time");
  end

  initial begin
    void'($urandom(32'h95a3));
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    repeat (4) @(negedge clk);
    check_level("rsp0_valid_o", rsp_valid[0], 1'b0);
    check_level("rsp1_valid_o", rsp_valid[1], 1'b0);
    check_level("req0_ready_o", req_ready[0], 1'b1);
    check_level("req1_ready_o", req_ready[1], 1'b1);

    // preload every pool word so later reads are defined
    for (int unsigned i = 0; i < PoolSize; i++) begin
      if (i % 2 == 0) pend0_q.push_back(make_req(1'b1, pool_addr(i), {$urandom, $urandom}));
      else pend1_q.push_back(make_req(1'b1, pool_addr(i), {$urandom, $urandom}));
    end
    wait_drained();

    // write then read back on port 0, bank 2 last opened at row 7
    pend0_q.push_back(make_req(1'b1, pool_addr(22), 64'h0123_4567_89ab_cdef));
    pend0_q.push_back(make_req(1'b0, pool_addr(22), '0));
    pend0_q.push_back(make_req(1'b1, pool_addr(22) + 8, 64'hfeed_face_cafe_beef));
    pend0_q.push_back(make_req(1'b0, pool_addr(22) + 8, '0));
    wait_drained();

    // concurrent random traffic on both ports
    gaps = 1'b1;
    for (int i = 0; i < 150; i++) begin
      pend0_q.push_back(rand_req());
      pend1_q.push_back(rand_req());
    end
    wait_drained();

    // both ports valid back to back
    gaps   = 1'b0;
    alt_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      pend0_q.push_back(rand_req());
      pend1_q.push_back(rand_req());
    end
    wait_drained();
    alt_en = 1'b0;

    // response back-pressure on both ports
    gaps       = 1'b1;
    rand_ready = 1'b1;
    for (int i = 0; i < 90; i++) begin
      pend0_q.push_back(rand_req());
      pend1_q.push_back(rand_req());
    end
    wait_drained();
    rand_ready = 1'b0;

    // long enough for the last access and a full response queue to drain
    repeat (20) @(negedge clk);
    check_level("rsp0_valid_o", rsp_valid[0], 1'b0);
    check_level("rsp1_valid_o", rsp_valid[1], 1'b0);
    if (exp0_q.size() == 0 && exp1_q.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      abort_run("reads left without a response at the end of the run");
    end
  end

endmodule : tb_mem_subsys

// ==== sim.f ====
+incdir+verilog
verilog/dram_pkg.sv
verilog/mem_req_arbiter.sv
verilog/mem_rsp_router.sv
verilog/sim_dram.sv
verilog/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

TOP := tb_mem_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f sim.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^No errors$$" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
